//--- source/net_consts.svh
/* ring network constants
   widths, port indices, ring size and input queue depth */

`ifndef NET_CONSTS_SVH
`define NET_CONSTS_SVH

// -------------------- sizes
`define NET_NUM_PORTS     3
`define NET_NUM_ROUTERS   8
`define NET_QUEUE_DEPTH   2

// -------------------- message fields
`define NET_SRCDEST_NBITS 3
`define NET_OPAQUE_NBITS  3
`define NET_PAYLOAD_NBITS 32

// -------------------- port indices
`define NET_PORT_WEST     0
`define NET_PORT_TERM     1
`define NET_PORT_EAST     2

`endif

//--- source/net_pkg.sv
/* ring network types
   node id, opaque tag, payload, per-port vectors and the packed message */

`include "net_consts.svh"

package net_pkg;

  // node ids are used for both dest and src
  typedef logic [`NET_SRCDEST_NBITS-1:0] node_id_t;
  typedef logic [`NET_OPAQUE_NBITS-1:0]  opaque_t;
  typedef logic [`NET_PAYLOAD_NBITS-1:0] payload_t;

  // one bit per router port
  typedef logic [`NET_NUM_PORTS-1:0]     port_vec_t;

  // -------------------- message
  // control word and payload travel together
  typedef struct packed {
    node_id_t dest;
    node_id_t src;
    opaque_t  opaque;
    payload_t payload;
  } net_msg_t;

endpackage

//--- source/router_in_port.sv
/* router input port
   two-entry circular queue plus ring route computation for the head message */

`timescale 1ns/1ps
`include "net_consts.svh"

module router_in_port #(
  parameter int p_router_id = 0,
  parameter int p_port      = 0
) (
  input  logic                clk,
  input  logic                arst_n,

  input  logic                in_val,
  output logic                in_rdy,
  input  net_pkg::net_msg_t   in_msg,

  input  logic                deq,

  output net_pkg::port_vec_t  reqs,
  output net_pkg::net_msg_t   head_msg
);

  localparam int c_ptr_nbits = (`NET_QUEUE_DEPTH > 1) ? $clog2(`NET_QUEUE_DEPTH) : 1;
  localparam int c_cnt_nbits = $clog2(`NET_QUEUE_DEPTH + 1);

  net_pkg::net_msg_t       entries [`NET_QUEUE_DEPTH];
  logic [c_ptr_nbits-1:0]  wr_ptr;
  logic [c_ptr_nbits-1:0]  rd_ptr;
  logic [c_cnt_nbits-1:0]  count;
  logic                    empty;
  logic                    enq;
  logic                    pop;
  net_pkg::node_id_t       fwd_dist;

  function automatic logic [c_ptr_nbits-1:0] ptr_inc(input logic [c_ptr_nbits-1:0] ptr);
    return (ptr == c_ptr_nbits'(`NET_QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // -------------------- queue
  assign empty  = (count == '0);
  assign in_rdy = (count != c_cnt_nbits'(`NET_QUEUE_DEPTH));
  assign enq    = in_val && in_rdy;
  assign pop    = deq && !empty;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (enq) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      // push and pop together leave the count alone
      if (enq && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !enq) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (enq) begin
      entries[wr_ptr] <= in_msg;
    end
  end

  assign head_msg = entries[rd_ptr];

  // -------------------- route
  // forward distance wraps with the node id width
  assign fwd_dist = head_msg.dest - net_pkg::node_id_t'(p_router_id);

  always_comb begin
    reqs = '0;
    if (!empty) begin
      if (head_msg.dest == net_pkg::node_id_t'(p_router_id)) begin
        reqs[`NET_PORT_TERM] = 1'b1;
      end else if (p_port == `NET_PORT_WEST) begin
        reqs[`NET_PORT_EAST] = 1'b1;
      end else if (p_port == `NET_PORT_EAST) begin
        reqs[`NET_PORT_WEST] = 1'b1;
      end else if (fwd_dist <= (`NET_NUM_ROUTERS / 2)) begin
        // shortest way round, a tie goes east
        reqs[`NET_PORT_EAST] = 1'b1;
      end else begin
        reqs[`NET_PORT_WEST] = 1'b1;
      end
    end
  end

endmodule

//--- source/router_rr_arbiter.sv
/* round-robin arbiter for one output port
   grants only while the output is ready */

`timescale 1ns/1ps
`include "net_consts.svh"

module router_rr_arbiter (
  input  logic                clk,
  input  logic                arst_n,

  input  net_pkg::port_vec_t  reqs,
  input  logic                en,
  output net_pkg::port_vec_t  grants
);

  localparam int c_num       = `NET_NUM_PORTS;
  localparam int c_idx_nbits = $clog2(c_num);

  logic [c_idx_nbits-1:0] prio;
  logic [c_idx_nbits-1:0] winner;
  logic                   found;

  // search upward from the priority pointer, wrapping past the top
  always_comb begin
    grants = '0;
    winner = prio;
    found  = 1'b0;
    for (int k = 0; k < c_num; k++) begin
      if (!found && reqs[(int'(prio) + k) % c_num]) begin
        found  = 1'b1;
        winner = c_idx_nbits'((int'(prio) + k) % c_num);
      end
    end
    if (en && found) begin
      grants[winner] = 1'b1;
    end
  end

  // -------------------- priority
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      prio <= '0;
    end else if (|grants) begin
      // winner drops to lowest priority
      prio <= (winner == c_idx_nbits'(c_num - 1)) ? '0 : winner + 1'b1;
    end
  end

endmodule

//--- source/router_switch.sv
/* router switch
   per-output arbiters, message crossbar and dequeue strobes to the inputs */

`timescale 1ns/1ps
`include "net_consts.svh"

module router_switch (
  input  logic                clk,
  input  logic                arst_n,

  input  net_pkg::port_vec_t  reqs     [`NET_NUM_PORTS],
  input  net_pkg::net_msg_t   head_msg [`NET_NUM_PORTS],
  output net_pkg::port_vec_t  deq,

  output net_pkg::port_vec_t  out_val,
  input  net_pkg::port_vec_t  out_rdy,
  output net_pkg::net_msg_t   out_msg  [`NET_NUM_PORTS]
);

  localparam int c_num       = `NET_NUM_PORTS;
  localparam int c_idx_nbits = $clog2(c_num);

  // both indexed by output, bit i stands for input i
  net_pkg::port_vec_t      out_reqs [c_num];
  net_pkg::port_vec_t      grants   [c_num];
  logic [c_idx_nbits-1:0]  xbar_sel [c_num];

  // -------------------- requests
  always_comb begin
    for (int j = 0; j < c_num; j++) begin
      for (int i = 0; i < c_num; i++) begin
        out_reqs[j][i] = reqs[i][j];
      end
    end
  end

  // -------------------- arbiters
  for (genvar j = 0; j < c_num; j++) begin : g_out
    router_rr_arbiter u_arb (
      .clk    (clk),
      .arst_n (arst_n),
      .reqs   (out_reqs[j]),
      .en     (out_rdy[j]),
      .grants (grants[j])
    );

    assign out_val[j] = |out_reqs[j];
  end

  // -------------------- crossbar
  // lowest requester while stalled, the granted input otherwise
  always_comb begin
    for (int j = 0; j < c_num; j++) begin
      xbar_sel[j] = '0;
      for (int i = c_num - 1; i >= 0; i--) begin
        if (out_reqs[j][i]) begin
          xbar_sel[j] = c_idx_nbits'(i);
        end
      end
      for (int i = 0; i < c_num; i++) begin
        if (grants[j][i]) begin
          xbar_sel[j] = c_idx_nbits'(i);
        end
      end
      out_msg[j] = head_msg[xbar_sel[j]];
    end
  end

  // an input pops when any output takes it
  always_comb begin
    deq = '0;
    for (int j = 0; j < c_num; j++) begin
      deq = deq | grants[j];
    end
  end

endmodule

//--- source/router_top.sv
/* ring router node
   west, terminal and east input ports drained by one switch */

`timescale 1ns/1ps
`include "net_consts.svh"

module router_top #(
  parameter int p_router_id = 0
) (
  input  logic                clk,
  input  logic                arst_n,

  input  net_pkg::port_vec_t  in_val,
  output net_pkg::port_vec_t  in_rdy,
  input  net_pkg::net_msg_t   in_msg  [`NET_NUM_PORTS],

  output net_pkg::port_vec_t  out_val,
  input  net_pkg::port_vec_t  out_rdy,
  output net_pkg::net_msg_t   out_msg [`NET_NUM_PORTS]
);

  // input port to switch
  net_pkg::port_vec_t  reqs     [`NET_NUM_PORTS];
  net_pkg::net_msg_t   head_msg [`NET_NUM_PORTS];
  net_pkg::port_vec_t  deq;

  // -------------------- input ports
  // p_port selects the routing rule, 0 west, 1 terminal, 2 east
  for (genvar i = 0; i < `NET_NUM_PORTS; i++) begin : g_in
    router_in_port #(
      .p_router_id (p_router_id),
      .p_port      (i)
    ) u_in_port (
      .clk      (clk),
      .arst_n   (arst_n),
      .in_val   (in_val[i]),
      .in_rdy   (in_rdy[i]),
      .in_msg   (in_msg[i]),
      .deq      (deq[i]),
      .reqs     (reqs[i]),
      .head_msg (head_msg[i])
    );
  end

  // -------------------- switch
  router_switch u_switch (
    .clk      (clk),
    .arst_n   (arst_n),
    .reqs     (reqs),
    .head_msg (head_msg),
    .deq      (deq),
    .out_val  (out_val),
    .out_rdy  (out_rdy),
    .out_msg  (out_msg)
  );

endmodule

//--- sim/router_tb.sv
/* ring router node testbench
   reset, latency, routing, round-robin order and back-pressure against a scoreboard */

`timescale 1ns/1ps
`include "net_consts.svh"

module router_tb;

  localparam int router_id  = 3;
  localparam int num_ports  = `NET_NUM_PORTS;
  localparam int num_pairs  = `NET_NUM_PORTS * `NET_NUM_PORTS;
  localparam int fifo_depth = 512;
  localparam int max_cycles = 4000;

  logic                 clk;
  logic                 arst_n;
  net_pkg::port_vec_t   in_val;
  net_pkg::port_vec_t   in_rdy;
  net_pkg::net_msg_t    in_msg  [num_ports];
  net_pkg::port_vec_t   out_val;
  net_pkg::port_vec_t   out_rdy;
  net_pkg::net_msg_t    out_msg [num_ports];

  // expected fifos, indexed by input * 3 + output
  net_pkg::net_msg_t    exp_mem [num_pairs][fifo_depth];
  int                   exp_wr  [num_pairs];
  int                   exp_rd  [num_pairs];
  int                   occ     [num_ports];
  logic [num_ports-1:0] stalled;
  net_pkg::net_msg_t    stall_msg [num_ports];
  int                   cycle;
  int                   seq_num;
  logic [31:0]          lfsr_state;
  string                test_name;

  router_top #(.p_router_id(router_id)) u_dut (
    .clk     (clk),
    .arst_n  (arst_n),
    .in_val  (in_val),
    .in_rdy  (in_rdy),
    .in_msg  (in_msg),
    .out_val (out_val),
    .out_rdy (out_rdy),
    .out_msg (out_msg)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // sized for about 400 messages at up to ten cycles each
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= max_cycles) begin
      $display("*** TEST FAILED ***");
      $fatal(1, "run did not finish within %0d cycles", max_cycles);
    end
  end

  // -------------------- helpers
  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v[k] = lfsr_state[0];
    end
  endtask

  // expected output port for a message entering on port
  function automatic int route_ref(input int port, input int dest);
    int fwd;
    fwd = (dest - router_id + `NET_NUM_ROUTERS) % `NET_NUM_ROUTERS;
    if (dest == router_id) return `NET_PORT_TERM;
    if (port == `NET_PORT_WEST) return `NET_PORT_EAST;
    if (port == `NET_PORT_EAST) return `NET_PORT_WEST;
    if (fwd <= `NET_NUM_ROUTERS / 2) return `NET_PORT_EAST;
    return `NET_PORT_WEST;
  endfunction

  // opaque carries the input port, payload a running sequence number
  function automatic net_pkg::net_msg_t next_msg(input int port, input int dest);
    net_pkg::net_msg_t m;
    m.dest    = net_pkg::node_id_t'(dest);
    m.src     = net_pkg::node_id_t'(seq_num);
    m.opaque  = net_pkg::opaque_t'(port);
    m.payload = net_pkg::payload_t'(seq_num);
    seq_num   = seq_num + 1;
    return m;
  endfunction

  task automatic report_mismatch(input string what, input logic [63:0] expected,
                                 input logic [63:0] actual);
    $display("** Error %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
    $display("*** TEST FAILED ***");
    $fatal(1, "value mismatch");
  endtask

  task automatic report_failure(input string what);
    $display("%s: %s", test_name, what);
    $display("*** TEST FAILED ***");
    $fatal(1, "check failed");
  endtask

  // -------------------- scoreboard
  always @(posedge clk) begin : monitor
    int f;
    int src;
    if (!arst_n) begin
      assert (out_val == '0 && in_rdy == '1)
        else report_failure("outputs not idle during reset");
    end else begin
      for (int i = 0; i < num_ports; i++) begin
        assert (in_rdy[i] == (occ[i] < 2))
          else report_mismatch($sformatf("in_rdy[%0d]", i), occ[i] < 2, in_rdy[i]);
      end
      // a stalled message stays at its input's head
      for (int j = 0; j < num_ports; j++) begin
        if (stalled[j] && out_val[j] && out_msg[j].opaque == stall_msg[j].opaque) begin
          assert (out_msg[j] == stall_msg[j])
            else report_mismatch($sformatf("stalled out_msg[%0d]", j), stall_msg[j],
                                 out_msg[j]);
        end
      end
      for (int i = 0; i < num_ports; i++) begin
        if (in_val[i] && in_rdy[i]) begin
          f = i * num_ports + route_ref(i, in_msg[i].dest);
          exp_mem[f][exp_wr[f] % fifo_depth] = in_msg[i];
          exp_wr[f] = exp_wr[f] + 1;
          occ[i]    = occ[i] + 1;
        end
      end
      for (int j = 0; j < num_ports; j++) begin
        if (out_val[j] && out_rdy[j]) begin
          assert (out_msg[j].opaque < num_ports)
            else report_failure($sformatf("output %0d carries a bad opaque tag", j));
          src = out_msg[j].opaque;
          f   = src * num_ports + j;
          assert (exp_rd[f] != exp_wr[f])
            else report_failure($sformatf("unexpected message from input %0d on output %0d",
                                          src, j));
          assert (out_msg[j] == exp_mem[f][exp_rd[f] % fifo_depth])
            else report_mismatch($sformatf("out_msg[%0d]", j),
                                 exp_mem[f][exp_rd[f] % fifo_depth], out_msg[j]);
          exp_rd[f] = exp_rd[f] + 1;
          occ[src]  = occ[src] - 1;
        end
      end
      for (int j = 0; j < num_ports; j++) begin
        stalled[j]   = out_val[j] && !out_rdy[j];
        stall_msg[j] = out_msg[j];
      end
    end
  end

  // -------------------- stimulus
  task automatic send_one(input int port, input int dest);
    @(posedge clk);
    in_val[port] <= 1'b1;
    in_msg[port] <= next_msg(port, dest);
    do @(posedge clk); while (!in_rdy[port]);
    in_val[port] <= 1'b0;
  endtask

  // the router is empty once no output has a message waiting
  task automatic wait_drain();
    do @(negedge clk); while (out_val != '0);
  endtask

  task automatic check_latency();
    int t0;
    test_name = "latency";
    send_one(`NET_PORT_TERM, router_id);
    t0 = cycle;
    do @(posedge clk); while (!(out_val[`NET_PORT_TERM] && out_rdy[`NET_PORT_TERM]));
    assert (cycle - t0 == 1) else report_mismatch("cycles to output", 1, cycle - t0);
    wait_drain();
  endtask

  task automatic check_routing();
    test_name = "routing";
    for (int p = 0; p < num_ports; p++) begin
      for (int d = 0; d < `NET_NUM_ROUTERS; d++) begin
        send_one(p, d);
        wait_drain();
      end
    end
  endtask

  task automatic check_round_robin();
    int last;
    int count;
    test_name = "round_robin";
    count = 0;
    last  = 0;
    @(posedge clk);
    in_val <= '1;
    for (int i = 0; i < num_ports; i++) begin
      in_msg[i] <= next_msg(i, router_id);
    end
    while (count < 30) begin
      @(posedge clk);
      for (int i = 0; i < num_ports; i++) begin
        if (in_val[i] && in_rdy[i]) begin
          in_msg[i] <= next_msg(i, router_id);
        end
      end
      if (out_val[`NET_PORT_TERM] && out_rdy[`NET_PORT_TERM]) begin
        if (count > 0) begin
          assert (out_msg[`NET_PORT_TERM].opaque == (last + 1) % num_ports)
            else report_mismatch("grant order", (last + 1) % num_ports,
                                 out_msg[`NET_PORT_TERM].opaque);
        end
        last  = out_msg[`NET_PORT_TERM].opaque;
        count = count + 1;
      end
    end
    in_val <= '0;
    wait_drain();
  endtask

  task automatic check_backpressure();
    int issued;
    logic [31:0] r;
    logic [31:0] d;
    test_name = "backpressure";
    issued = 0;
    while (issued < 300 || in_val != '0) begin
      @(posedge clk);
      for (int i = 0; i < num_ports; i++) begin
        // a refused message is held until it is taken
        if (!in_val[i] || in_rdy[i]) begin
          rand_bits(1, r);
          if (r[0] && issued < 300) begin
            rand_bits(3, d);
            in_val[i] <= 1'b1;
            in_msg[i] <= next_msg(i, d);
            issued = issued + 1;
          end else begin
            in_val[i] <= 1'b0;
          end
        end
      end
      rand_bits(num_ports, r);
      out_rdy <= r[num_ports-1:0];
    end
    @(posedge clk);
    out_rdy <= '1;
    wait_drain();
  endtask

  initial begin
    arst_n     = 1'b0;
    in_val     = '0;
    out_rdy    = '1;
    cycle      = 0;
    seq_num    = 0;
    stalled    = '0;
    lfsr_state = 32'h570081de;
    test_name  = "reset";
    for (int i = 0; i < num_ports; i++) begin
      in_msg[i] = '0;
      occ[i]    = 0;
    end
    for (int f = 0; f < num_pairs; f++) begin
      exp_wr[f] = 0;
      exp_rd[f] = 0;
    end
    repeat (10) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    assert (out_val == '0 && in_rdy == '1) else report_failure("outputs not idle after reset");

    check_latency();
    check_routing();
    check_round_robin();
    check_backpressure();

    test_name = "final";
    for (int f = 0; f < num_pairs; f++) begin
      assert (exp_rd[f] == exp_wr[f])
        else report_failure($sformatf("messages missing for input %0d, output %0d",
                                      f / num_ports, f % num_ports));
    end
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

//--- build.f
+incdir+source
source/net_pkg.sv
source/router_in_port.sv
source/router_rr_arbiter.sv
source/router_switch.sv
source/router_top.sv
sim/router_tb.sv
